// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module frog_game_tb -f src.f -o frog_game_sim
	./obj_dir/frog_game_sim | tee /dev/stderr | grep -q -F '*** PASSED ***'

clean:
	rm -rf obj_dir

// File: design/dpad_input.sv
`timescale 1ns/1ps

module dpad_input (
    input  logic                clk,
    input  logic                arst_n,
    input  frogger_pkg::dpad_t  buttons,
    input  logic                frame_end,
    output frogger_pkg::dpad_t  press
);

    frogger_pkg::dpad_t sync_meta;   // first synchroniser stage
    frogger_pkg::dpad_t sync_q;      // buttons in the clock domain
    frogger_pkg::dpad_t prev_q;      // last cycle's level for edge detection
    frogger_pkg::dpad_t rise;
    frogger_pkg::dpad_t first_rise;  // one-hot pick among simultaneous edges
    frogger_pkg::dpad_t pending;     // press waiting for the next frame boundary

    assign rise = sync_q & ~prev_q;

    // same-cycle edges resolve as up, down, left, right
    always_comb begin
        first_rise = '0;
        if (rise.up) begin
            first_rise.up = 1'b1;
        end else if (rise.down) begin
            first_rise.down = 1'b1;
        end else if (rise.left) begin
            first_rise.left = 1'b1;
        end else if (rise.right) begin
            first_rise.right = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_meta <= '0;
            sync_q    <= '0;
            prev_q    <= '0;
            pending   <= '0;
        end else begin
            sync_meta <= buttons;
            sync_q    <= sync_meta;
            prev_q    <= sync_q;
            // later edges are ignored until the pending press has been handed over
            if (frame_end || (pending == '0)) begin
                pending <= first_rise;
            end
        end
    end

    // only a rising edge is latched, so a held button gives a single press
    assign press = frame_end ? pending : '0;

endmodule

// File: design/frog_game_top.sv
`timescale 1ns/1ps

module frog_game_top #(
    parameter int H_ACTIVE  = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_ACTIVE  = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33,
    parameter int FROG_SIZE = 32,
    parameter int GRID_SIZE = 64
) (
    input  logic                clk,
    input  logic                arst_n,
    input  frogger_pkg::dpad_t  buttons,
    output logic                hsync,
    output logic                vsync,
    output frogger_pkg::color_t color,
    output frogger_pkg::dpad_t  jump,         // move pulses for a sound block
    output logic                reached_end,
    output logic [7:0]          crossings
);

    frogger_pkg::scan_t scan;
    logic               frame_end;
    frogger_pkg::dpad_t press;
    frogger_pkg::pos_t  pos;

    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) timing0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .scan      (scan),
        .frame_end (frame_end)
    );

    dpad_input dpad0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .buttons   (buttons),
        .frame_end (frame_end),
        .press     (press)
    );

    frog_motion #(
        .H_ACTIVE  (H_ACTIVE),
        .V_ACTIVE  (V_ACTIVE),
        .FROG_SIZE (FROG_SIZE)
    ) motion0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .press       (press),
        .pos         (pos),
        .jump        (jump),
        .reached_end (reached_end),
        .crossings   (crossings)
    );

    pixel_compose #(
        .FROG_SIZE (FROG_SIZE),
        .GRID_SIZE (GRID_SIZE)
    ) compose0 (
        .clk    (clk),
        .arst_n (arst_n),
        .scan   (scan),
        .pos    (pos),
        .color  (color),
        .hsync  (hsync),
        .vsync  (vsync)
    );

endmodule

// File: design/frog_motion.sv
`timescale 1ns/1ps

module frog_motion #(
    parameter int H_ACTIVE  = 640,
    parameter int V_ACTIVE  = 480,
    parameter int FROG_SIZE = 32
) (
    input  logic               clk,
    input  logic               arst_n,
    input  frogger_pkg::dpad_t press,
    output frogger_pkg::pos_t  pos,
    output frogger_pkg::dpad_t jump,
    output logic               reached_end,
    output logic [7:0]         crossings
);

    localparam logic [9:0] INIT_X = 10'(H_ACTIVE / 2);
    localparam logic [9:0] INIT_Y = 10'(V_ACTIVE - FROG_SIZE);
    localparam logic [9:0] X_MAX  = 10'(H_ACTIVE - FROG_SIZE);
    localparam logic [9:0] STEP   = 10'(FROG_SIZE);

    frogger_pkg::pos_t pos_next;
    logic              at_goal;   // an up move lands on row 0
    logic [10:0]       x_right;   // one extra bit so the clamp sees an overflow
    logic [10:0]       y_down;

    assign x_right = {1'b0, pos.x} + {1'b0, STEP};
    assign y_down  = {1'b0, pos.y} + {1'b0, STEP};

    // y never drops below one step away from the top, so this means the result is 0
    assign at_goal = press.up && (pos.y <= STEP);

    always_comb begin
        pos_next = pos;
        if (at_goal) begin
            pos_next.x = INIT_X;  // crossing done, start again at the bottom
            pos_next.y = INIT_Y;
        end else if (press.up) begin
            pos_next.y = pos.y - STEP;
        end else if (press.down) begin
            pos_next.y = (y_down > {1'b0, INIT_Y}) ? INIT_Y : y_down[9:0];
        end else if (press.left) begin
            pos_next.x = (pos.x < STEP) ? '0 : pos.x - STEP;
        end else if (press.right) begin
            pos_next.x = (x_right > {1'b0, X_MAX}) ? X_MAX : x_right[9:0];
        end
    end

    // press only ever arrives with frame_end, so pos holds still for the whole frame
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pos         <= '{x: INIT_X, y: INIT_Y};
            jump        <= '0;
            reached_end <= 1'b0;
            crossings   <= '0;
        end else begin
            pos         <= pos_next;
            jump        <= press;  // pulses even when a clamp leaves pos unchanged
            reached_end <= at_goal;
            if (at_goal) begin
                crossings <= crossings + 8'd1;  // wraps after 255
            end
        end
    end

endmodule

// File: design/frogger_pkg.sv
package frogger_pkg;

    // pixel colour as {red, green, blue}, two bits each
    typedef logic [5:0] color_t;

    // one raster position together with its sync levels
    typedef struct packed {
        logic [9:0] col;
        logic [9:0] row;
        logic       active;  // inside the visible window
        logic       hsync;   // active low
        logic       vsync;   // active low
    } scan_t;

    // direction buttons in the same bit order as the board pins
    typedef struct packed {
        logic right;
        logic up;
        logic down;
        logic left;
    } dpad_t;

    // top-left corner of the frog sprite in pixels
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
    } pos_t;

    localparam color_t FROG_COLOR  = 6'b001100;  // green
    localparam color_t GRID_COLOR  = 6'b101010;  // grey
    localparam color_t GOAL_COLOR  = 6'b000011;  // blue band along the top rows
    localparam color_t BG_COLOR    = 6'b010101;  // dark grey
    localparam color_t BLANK_COLOR = 6'b000000;  // DAC must see black while blanking

endpackage

// File: design/pixel_compose.sv
`timescale 1ns/1ps

module pixel_compose #(
    parameter int FROG_SIZE = 32,
    parameter int GRID_SIZE = 64
) (
    input  logic                clk,
    input  logic                arst_n,
    input  frogger_pkg::scan_t  scan,
    input  frogger_pkg::pos_t   pos,
    output frogger_pkg::color_t color,
    output logic                hsync,
    output logic                vsync
);

    localparam logic [10:0] SPRITE = 11'(FROG_SIZE);
    localparam logic [9:0]  GRID   = 10'(GRID_SIZE);

    logic                in_frog_x;
    logic                in_frog_y;
    logic                on_grid;
    logic                in_goal;
    frogger_pkg::color_t color_next;

    // sprite bounds use 11 bits so a frog at the right edge does not wrap
    assign in_frog_x = (scan.col >= pos.x) &&
                       ({1'b0, scan.col} < ({1'b0, pos.x} + SPRITE));
    assign in_frog_y = (scan.row >= pos.y) &&
                       ({1'b0, scan.row} < ({1'b0, pos.y} + SPRITE));

    assign on_grid = ((scan.col % GRID) == 10'd0) || ((scan.row % GRID) == 10'd0);
    assign in_goal = (scan.row < 10'(FROG_SIZE));

    always_comb begin
        if (!scan.active) begin
            color_next = frogger_pkg::BLANK_COLOR;
        end else if (in_frog_x && in_frog_y) begin
            color_next = frogger_pkg::FROG_COLOR;
        end else if (on_grid) begin
            color_next = frogger_pkg::GRID_COLOR;
        end else if (in_goal) begin
            color_next = frogger_pkg::GOAL_COLOR;
        end else begin
            color_next = frogger_pkg::BG_COLOR;
        end
    end

    // syncs go through the same register stage as the colour to stay aligned
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            color <= frogger_pkg::BLANK_COLOR;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            color <= color_next;
            hsync <= scan.hsync;
            vsync <= scan.vsync;
        end
    end

endmodule

// File: design/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic               clk,
    input  logic               arst_n,
    output frogger_pkg::scan_t scan,
    output logic               frame_end
);

    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

    logic [9:0]         col_cnt;
    logic [9:0]         row_cnt;
    logic               line_end;   // last column of the current line
    logic               last_row;   // last row of the frame
    logic               in_hsync;
    logic               in_vsync;
    frogger_pkg::scan_t scan_next;

    assign line_end = (col_cnt == 10'(H_TOTAL - 1));
    assign last_row = (row_cnt == 10'(V_TOTAL - 1));

    assign in_hsync = (col_cnt >= 10'(H_SYNC_START)) &&
                      (col_cnt < 10'(H_SYNC_START + H_SYNC));
    assign in_vsync = (row_cnt >= 10'(V_SYNC_START)) &&
                      (row_cnt < 10'(V_SYNC_START + V_SYNC));

    // free-running raster counters, row advances at the end of each line
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (line_end) begin
            col_cnt <= '0;
            row_cnt <= last_row ? '0 : row_cnt + 10'd1;
        end else begin
            col_cnt <= col_cnt + 10'd1;
        end
    end

    always_comb begin
        scan_next.col    = col_cnt;
        scan_next.row    = row_cnt;
        scan_next.active = (col_cnt < 10'(H_ACTIVE)) && (row_cnt < 10'(V_ACTIVE));
        scan_next.hsync  = !in_hsync;
        scan_next.vsync  = !in_vsync;
    end

    // frame_end is high in the same cycle that scan carries the final pixel
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scan      <= '{col: '0, row: '0, active: 1'b0, hsync: 1'b1, vsync: 1'b1};
            frame_end <= 1'b0;
        end else begin
            scan      <= scan_next;
            frame_end <= line_end && last_row;
        end
    end

endmodule

// File: dv/frog_game_checker.sv
`timescale 1ns/1ps

module frog_game_checker #(
    parameter int H_ACTIVE  = 640,
    parameter int V_ACTIVE  = 480,
    parameter int FROG_SIZE = 32
) (
    input logic               clk,
    input logic               arst_n,
    input frogger_pkg::pos_t  pos,
    input frogger_pkg::dpad_t jump,
    input logic               reached_end
);

    localparam logic [9:0] X_MAX  = 10'(H_ACTIVE - FROG_SIZE);
    localparam logic [9:0] INIT_Y = 10'(V_ACTIVE - FROG_SIZE);

    int unsigned fail_cnt = 0;  // failed assertions, the testbench turns this into its verdict

    jump_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(jump))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("jump carries more than one direction");
        end

    // a crossing is reported in a single cycle only
    end_single: assert property (@(posedge clk) disable iff (!arst_n)
        reached_end |=> !reached_end)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("reached_end held for more than one cycle");
        end

    x_in_field: assert property (@(posedge clk) disable iff (!arst_n) pos.x <= X_MAX)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("frog x is past the right edge");
        end

    y_in_field: assert property (@(posedge clk) disable iff (!arst_n) pos.y <= INIT_Y)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("frog y is below the start row");
        end

endmodule

// File: dv/frog_game_tb.sv
`timescale 1ns/1ps

module frog_game_tb;

    localparam int H_ACTIVE    = 64;
    localparam int H_FRONT     = 4;
    localparam int H_SYNC      = 8;
    localparam int H_BACK      = 4;
    localparam int V_ACTIVE    = 48;
    localparam int V_FRONT     = 2;
    localparam int V_SYNC      = 2;
    localparam int V_BACK      = 2;
    localparam int FROG_SIZE   = 8;
    localparam int GRID_SIZE   = 16;
    localparam int H_TOTAL     = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL     = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_LEN   = H_TOTAL * V_TOTAL;
    localparam int INIT_X      = H_ACTIVE / 2;
    localparam int INIT_Y      = V_ACTIVE - FROG_SIZE;
    localparam int TEST_FRAMES = 37;  // two frames per move, the raster frames and the held frame
    localparam int CYCLE_LIMIT = TEST_FRAMES * FRAME_LEN * 2;

    localparam frogger_pkg::dpad_t NONE_BTN  = 4'b0000;
    localparam frogger_pkg::dpad_t RIGHT_BTN = 4'b1000;
    localparam frogger_pkg::dpad_t UP_BTN    = 4'b0100;
    localparam frogger_pkg::dpad_t DOWN_BTN  = 4'b0010;
    localparam frogger_pkg::dpad_t LEFT_BTN  = 4'b0001;

    logic                clk;
    logic                arst_n;
    frogger_pkg::dpad_t  buttons;
    logic                hsync;
    logic                vsync;
    frogger_pkg::color_t color;
    frogger_pkg::dpad_t  jump;
    logic                reached_end;
    logic [7:0]          crossings;

    int   disp_col;   // raster position the pins show in this cycle
    int   disp_row;
    int   frog_x;     // frog position the model expects on screen
    int   frog_y;
    int   cross_cnt;
    logic exp_goal;
    int   cycle_cnt;

    frog_game_top #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK),
        .FROG_SIZE (FROG_SIZE), .GRID_SIZE (GRID_SIZE)
    ) dut0 (
        .clk (clk), .arst_n (arst_n), .buttons (buttons), .hsync (hsync), .vsync (vsync),
        .color (color), .jump (jump), .reached_end (reached_end), .crossings (crossings)
    );

    bind frog_motion frog_game_checker #(
        .H_ACTIVE (H_ACTIVE), .V_ACTIVE (V_ACTIVE), .FROG_SIZE (FROG_SIZE)
    ) checker0 (
        .clk (clk), .arst_n (arst_n), .pos (pos), .jump (jump), .reached_end (reached_end)
    );

    always #50 clk = ~clk;

    // the pins lag the DUT counters by two registers, hence the start two places back
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            disp_col <= H_TOTAL - 2;
            disp_row <= V_TOTAL - 1;
        end else if (disp_col == H_TOTAL - 1) begin
            disp_col <= 0;
            disp_row <= (disp_row == V_TOTAL - 1) ? 0 : disp_row + 1;
        end else begin
            disp_col <= disp_col + 1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (dut0.motion0.checker0.fail_cnt != 0) begin
            $display("an assertion on the frog motion failed");
            $display("*** FAILED ***");
            $fatal(1, "stopped at the first assertion failure");
        end else if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERR %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic frogger_pkg::color_t expected_color(input int col, input int row);
        frogger_pkg::color_t c;
        if (col >= H_ACTIVE || row >= V_ACTIVE) begin
            c = frogger_pkg::BLANK_COLOR;
        end else if (col >= frog_x && col < frog_x + FROG_SIZE &&
                     row >= frog_y && row < frog_y + FROG_SIZE) begin
            c = frogger_pkg::FROG_COLOR;
        end else if (col % GRID_SIZE == 0 || row % GRID_SIZE == 0) begin
            c = frogger_pkg::GRID_COLOR;
        end else if (row < FROG_SIZE) begin
            c = frogger_pkg::GOAL_COLOR;
        end else begin
            c = frogger_pkg::BG_COLOR;
        end
        return c;
    endfunction

    function automatic frogger_pkg::dpad_t dir_from_index(input int idx);
        case (idx)
            0:       return UP_BTN;
            1:       return DOWN_BTN;
            2:       return LEFT_BTN;
            default: return RIGHT_BTN;
        endcase
    endfunction

    task automatic wait_display(input int col, input int row);
        @(negedge clk);
        while (!(disp_col == col && disp_row == row)) @(negedge clk);
    endtask

    // checks one whole frame and returns at the negedge showing its last pixel
    task automatic check_frame();
        int   i;
        logic exp_hs;
        logic exp_vs;
        wait_display(0, 0);
        for (i = 0; i < FRAME_LEN; i++) begin
            exp_hs = !(disp_col >= H_ACTIVE + H_FRONT && disp_col < H_ACTIVE + H_FRONT + H_SYNC);
            exp_vs = !(disp_row >= V_ACTIVE + V_FRONT && disp_row < V_ACTIVE + V_FRONT + V_SYNC);
            check_equal(32'(color), 32'(expected_color(disp_col, disp_row)),
                        $sformatf("color at (%0d,%0d)", disp_col, disp_row));
            check_equal(32'(hsync), 32'(exp_hs), $sformatf("hsync at column %0d", disp_col));
            check_equal(32'(vsync), 32'(exp_vs), $sformatf("vsync at row %0d", disp_row));
            if (i != FRAME_LEN - 1) begin
                check_equal(32'(jump), 32'(NONE_BTN), "jump inside the frame");
                check_equal(32'(reached_end), 32'd0, "reached_end inside the frame");
                @(negedge clk);
            end
        end
    endtask

    task automatic apply_move(input frogger_pkg::dpad_t b);
        exp_goal = 1'b0;
        if (b.left) begin
            frog_x = (frog_x - FROG_SIZE < 0) ? 0 : frog_x - FROG_SIZE;
        end else if (b.right) begin
            frog_x = (frog_x + FROG_SIZE > H_ACTIVE - FROG_SIZE) ? H_ACTIVE - FROG_SIZE :
                     frog_x + FROG_SIZE;
        end else if (b.down) begin
            frog_y = (frog_y + FROG_SIZE > INIT_Y) ? INIT_Y : frog_y + FROG_SIZE;
        end else if (b.up) begin
            frog_y = frog_y - FROG_SIZE;
            if (frog_y == 0) begin  // top reached, frog restarts at the bottom
                exp_goal  = 1'b1;
                cross_cnt = (cross_cnt + 1) % 256;
                frog_x    = INIT_X;
                frog_y    = INIT_Y;
            end
        end
    endtask

    // the frame boundary is visible at the pins while they show the last pixel
    task automatic check_boundary(input frogger_pkg::dpad_t dir);
        check_equal(32'(jump), 32'(dir), "jump at the frame boundary");
        check_equal(32'(reached_end), 32'(exp_goal), "reached_end at the frame boundary");
        check_equal(32'(crossings), 32'(cross_cnt), "crossings");
    endtask

    task automatic pulse_button(input frogger_pkg::dpad_t b, input logic release_after);
        @(posedge clk);
        buttons <= b;
        repeat (4) @(posedge clk);
        if (release_after) buttons <= NONE_BTN;
        repeat (4) @(posedge clk);  // gap so that the next press is a fresh edge
    endtask

    // press during frame N, which keeps the old picture, and expect the move in frame N+1
    task automatic move_and_check(input frogger_pkg::dpad_t b, input logic release_after);
        fork
            begin
                wait_display(0, 0);
                pulse_button(b, release_after);
            end
            check_frame();
        join
        apply_move(b);
        check_boundary(b);
        check_frame();
    endtask

    task automatic raster_test();
        check_frame();
        check_frame();
    endtask

    task automatic single_move_test();
        move_and_check(LEFT_BTN, 1'b1);
        move_and_check(RIGHT_BTN, 1'b1);
        move_and_check(UP_BTN, 1'b1);
        move_and_check(DOWN_BTN, 1'b1);
    endtask

    task automatic clamp_and_hold_test();
        int k;
        for (k = 0; k < 4; k++) move_and_check(RIGHT_BTN, 1'b1);  // the last one hits the edge
        move_and_check(DOWN_BTN, 1'b1);
        move_and_check(LEFT_BTN, 1'b0);
        apply_move(NONE_BTN);
        check_boundary(NONE_BTN);  // still held, no second move
        check_frame();
        @(posedge clk);
        buttons <= NONE_BTN;
    endtask

    task automatic crossing_test();
        int k;
        for (k = 0; k < 5; k++) move_and_check(UP_BTN, 1'b1);
    endtask

    task automatic one_press_per_frame_test();
        frogger_pkg::dpad_t dirs [3];
        int                 rep;
        int                 k;
        int                 idx;
        for (rep = 0; rep < 2; rep++) begin
            for (k = 0; k < 3; k++) begin
                idx     = $urandom_range(3, 0);
                dirs[k] = dir_from_index(idx);
            end
            fork
                begin
                    wait_display(0, 0);
                    pulse_button(dirs[0], 1'b1);
                    pulse_button(dirs[1], 1'b1);
                    pulse_button(dirs[2], 1'b1);
                end
                check_frame();
            join
            apply_move(dirs[0]);
            check_boundary(dirs[0]);
            check_frame();
        end
    endtask

    initial begin
        void'($urandom(32'h834e473f));
        clk       = 1'b0;
        arst_n    = 1'b0;
        buttons   = NONE_BTN;
        frog_x    = INIT_X;
        frog_y    = INIT_Y;
        cross_cnt = 0;
        exp_goal  = 1'b0;
        cycle_cnt = 0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        raster_test();
        single_move_test();
        clamp_and_hold_test();
        crossing_test();
        one_press_per_frame_test();
        if (dut0.motion0.checker0.fail_cnt != 0) begin
            $display("an assertion on the frog motion failed");
            $display("*** FAILED ***");
            $fatal(1, "assertion failures in the frog motion checker");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// File: src.f
design/frogger_pkg.sv
design/vga_timing.sv
design/dpad_input.sv
design/frog_motion.sv
design/pixel_compose.sv
design/frog_game_top.sv
dv/frog_game_checker.sv
dv/frog_game_tb.sv
